// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_loog
RTL_TOP   ?= loog_core
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= sim passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)
	$(VERILATOR) --lint-only --timing --assert --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// File: hw/exec_unit.sv
// unknown encodings retire as no-ops; r0 reads zero and a write to it retires without we
`timescale 1ns/1ps

module exec_unit (
    input  logic                              clk,
    input  logic                              rst_n_i,
    input  logic                              in_valid_i,
    input  logic [loog_pkg::XLEN-1:0]         in_pc_i,
    input  loog_pkg::inst_word_u              in_inst_i,
    output logic                              allowin_o,
    output logic [loog_pkg::XLEN-1:0]         debug_wb_pc_o,
    output logic [3:0]                        debug_wb_rf_we_o,
    output logic [loog_pkg::REG_ADDR_W-1:0]   debug_wb_rf_wnum_o,
    output logic [loog_pkg::XLEN-1:0]         debug_wb_rf_wdata_o
);
    logic [loog_pkg::XLEN-1:0]       rf_q [1 << loog_pkg::REG_ADDR_W];
    logic [loog_pkg::REG_ADDR_W-1:0] rj;
    logic [loog_pkg::REG_ADDR_W-1:0] rk;
    logic [loog_pkg::REG_ADDR_W-1:0] rd;
    logic [loog_pkg::XLEN-1:0]       rj_val;
    logic [loog_pkg::XLEN-1:0]       rk_val;
    logic [loog_pkg::XLEN-1:0]       imm_sext;
    logic [loog_pkg::XLEN-1:0]       imm_zext;
    logic [loog_pkg::XLEN-1:0]       r3_result;
    logic [loog_pkg::XLEN-1:0]       ri_result;
    logic [loog_pkg::XLEN-1:0]       result;
    logic                            r3_hit;
    logic                            ri_hit;
    logic                            fire;
    logic                            wr_en;
    logic                            trace_we_q;
    logic [loog_pkg::XLEN-1:0]       trace_pc_q;
    logic [loog_pkg::REG_ADDR_W-1:0] trace_wnum_q;
    logic [loog_pkg::XLEN-1:0]       trace_wdata_q;

    // single stage, always ready
    assign allowin_o = 1'b1;
    assign fire      = in_valid_i && allowin_o;

    // register fields sit in the same bits in both formats
    assign rj = in_inst_i.r3.rj;
    assign rk = in_inst_i.r3.rk;
    assign rd = in_inst_i.r3.rd;

    assign rj_val   = (rj == '0) ? '0 : rf_q[rj];
    assign rk_val   = (rk == '0) ? '0 : rf_q[rk];
    assign imm_sext = {{(loog_pkg::XLEN - 12){in_inst_i.ri12.si12[11]}}, in_inst_i.ri12.si12};
    assign imm_zext = {{(loog_pkg::XLEN - 12){1'b0}}, in_inst_i.ri12.si12};

    // 3R view
    always_comb begin
        r3_hit    = 1'b1;
        r3_result = '0;
        case (in_inst_i.r3.opcode)
            loog_pkg::OP_ADD_W: r3_result = rj_val + rk_val;
            loog_pkg::OP_SUB_W: r3_result = rj_val - rk_val;
            loog_pkg::OP_AND:   r3_result = rj_val & rk_val;
            loog_pkg::OP_OR:    r3_result = rj_val | rk_val;
            loog_pkg::OP_XOR:   r3_result = rj_val ^ rk_val;
            default:            r3_hit    = 1'b0;
        endcase
    end

    // 2RI12 view, logic ops take the immediate unsigned
    always_comb begin
        ri_hit    = 1'b1;
        ri_result = '0;
        case (in_inst_i.ri12.opcode)
            loog_pkg::OP_ADDI_W: ri_result = rj_val + imm_sext;
            loog_pkg::OP_ANDI:   ri_result = rj_val & imm_zext;
            loog_pkg::OP_ORI:    ri_result = rj_val | imm_zext;
            default:             ri_hit    = 1'b0;
        endcase
    end

    assign result = r3_hit ? r3_result : ri_result;
    assign wr_en  = (r3_hit || ri_hit) && (rd != '0);

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            trace_we_q <= 1'b0;
        end else begin
            trace_we_q <= fire && wr_en;
        end
    end

    // register file and trace payload update on the same edge
    always_ff @(posedge clk) begin
        if (fire) begin
            trace_pc_q    <= in_pc_i;
            trace_wnum_q  <= wr_en ? rd : '0;
            trace_wdata_q <= wr_en ? result : '0;
        end
        if (fire && wr_en) begin
            rf_q[rd] <= result;
        end
    end

    assign debug_wb_pc_o       = trace_pc_q;
    assign debug_wb_rf_we_o    = {4{trace_we_q}};
    assign debug_wb_rf_wnum_o  = trace_wnum_q;
    assign debug_wb_rf_wdata_o = trace_wdata_q;

    // r0 never shows up as a written register
    assert property (@(posedge clk) disable iff (!rst_n_i)
        debug_wb_rf_we_o != '0 |-> debug_wb_rf_wnum_o != '0);

endmodule

// File: hw/fetch_unit.sv
// memory must answer every accepted request exactly once, in order, no earlier than next cycle
`timescale 1ns/1ps

module fetch_unit #(
    parameter int QUEUE_DEPTH = 4
) (
    input  logic                              clk,
    input  logic                              rst_n_i,
    input  logic                              inst_sram_addr_ok_i,
    input  logic                              inst_sram_data_ok_i,
    input  logic [loog_pkg::XLEN-1:0]         inst_sram_rdata_i,
    input  logic [$clog2(QUEUE_DEPTH+1)-1:0]  queue_count_i,
    output logic                              inst_sram_req_o,
    output logic [loog_pkg::XLEN-1:0]         inst_sram_addr_o,
    output logic                              push_valid_o,
    output logic [loog_pkg::XLEN-1:0]         push_pc_o,
    output loog_pkg::inst_word_u              push_inst_o
);
    localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);
    localparam int PTR_W = $clog2(QUEUE_DEPTH);

    logic [loog_pkg::XLEN-1:0] pc_q;
    logic [loog_pkg::XLEN-1:0] inflight_pc_q [QUEUE_DEPTH];
    logic [PTR_W-1:0]          wr_ptr_q;
    logic [PTR_W-1:0]          rd_ptr_q;
    logic [CNT_W-1:0]          outstanding_q;
    logic [CNT_W:0]            credit_used;
    logic                      accept;

    // slots already spoken for: in flight, in the output register, in the queue
    assign credit_used = {1'b0, outstanding_q} + {{CNT_W{1'b0}}, push_valid_o}
                       + {1'b0, queue_count_i};

    // no request while held in reset
    assign inst_sram_req_o  = rst_n_i && (credit_used < (CNT_W + 1)'(QUEUE_DEPTH));
    assign inst_sram_addr_o = pc_q;
    assign accept           = inst_sram_req_o && inst_sram_addr_ok_i;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            pc_q          <= loog_pkg::RESET_PC;
            wr_ptr_q      <= '0;
            rd_ptr_q      <= '0;
            outstanding_q <= '0;
            push_valid_o  <= 1'b0;
        end else begin
            if (accept) begin
                pc_q     <= pc_q + (loog_pkg::XLEN)'(4);
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (inst_sram_data_ok_i) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            if (accept && !inst_sram_data_ok_i) begin
                outstanding_q <= outstanding_q + 1'b1;
            end else if (!accept && inst_sram_data_ok_i) begin
                outstanding_q <= outstanding_q - 1'b1;
            end
            push_valid_o <= inst_sram_data_ok_i;
        end
    end

    // pc of each request waits here until its word comes back
    always_ff @(posedge clk) begin
        if (accept) begin
            inflight_pc_q[wr_ptr_q] <= pc_q;
        end
        if (inst_sram_data_ok_i) begin
            push_pc_o   <= inflight_pc_q[rd_ptr_q];
            push_inst_o <= inst_sram_rdata_i;
        end
    end

    // response with nothing in flight
    assert property (@(posedge clk) disable iff (!rst_n_i)
        inst_sram_data_ok_i |-> outstanding_q != '0);

endmodule

// File: hw/inst_queue.sv
// QUEUE_DEPTH must be a power of two from 2 up; the producer must never push into a full queue
`timescale 1ns/1ps

module inst_queue #(
    parameter int QUEUE_DEPTH = 4
) (
    input  logic                              clk,
    input  logic                              rst_n_i,
    input  logic                              push_valid_i,
    input  logic [loog_pkg::XLEN-1:0]         push_pc_i,
    input  loog_pkg::inst_word_u              push_inst_i,
    input  logic                              allowin_i,
    output logic                              out_valid_o,
    output logic [loog_pkg::XLEN-1:0]         out_pc_o,
    output loog_pkg::inst_word_u              out_inst_o,
    output logic [$clog2(QUEUE_DEPTH+1)-1:0]  count_o
);
    // pc in the upper half, instruction word below
    localparam int ENTRY_W = loog_pkg::XLEN + 32;
    localparam int PTR_W   = $clog2(QUEUE_DEPTH);
    localparam int CNT_W   = $clog2(QUEUE_DEPTH + 1);

    logic [ENTRY_W-1:0] entry_q [QUEUE_DEPTH];
    logic [ENTRY_W-1:0] head;
    logic [PTR_W-1:0]   wr_ptr_q;
    logic [PTR_W-1:0]   rd_ptr_q;
    logic [CNT_W-1:0]   count_q;
    logic               pop;

    assign out_valid_o = count_q != '0;
    assign pop         = out_valid_o && allowin_i;
    assign head        = entry_q[rd_ptr_q];
    assign out_pc_o    = head[ENTRY_W-1 -: loog_pkg::XLEN];
    assign out_inst_o  = head[31:0];
    assign count_o     = count_q;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push_valid_i) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (pop) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            // simultaneous push and pop leaves the count alone
            if (push_valid_i && !pop) begin
                count_q <= count_q + 1'b1;
            end else if (!push_valid_i && pop) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push_valid_i) begin
            entry_q[wr_ptr_q] <= {push_pc_i, push_inst_i};
        end
    end

    // fetch credit keeps a full queue from seeing a push
    assert property (@(posedge clk) disable iff (!rst_n_i)
        push_valid_i |-> count_q != (CNT_W)'(QUEUE_DEPTH));

endmodule

// File: hw/loog_core.sv
// QUEUE_DEPTH must be a power of two from 2 up; no branches, so the PC only counts upward
`timescale 1ns/1ps

module loog_core #(
    parameter int QUEUE_DEPTH = 4
) (
    input  logic                              clk,
    input  logic                              rst_n_i,
    // instruction sram
    output logic                              inst_sram_req_o,
    output logic [loog_pkg::XLEN-1:0]         inst_sram_addr_o,
    input  logic                              inst_sram_addr_ok_i,
    input  logic                              inst_sram_data_ok_i,
    input  logic [loog_pkg::XLEN-1:0]         inst_sram_rdata_i,
    // retirement trace
    output logic [loog_pkg::XLEN-1:0]         debug_wb_pc_o,
    output logic [3:0]                        debug_wb_rf_we_o,
    output logic [loog_pkg::REG_ADDR_W-1:0]   debug_wb_rf_wnum_o,
    output logic [loog_pkg::XLEN-1:0]         debug_wb_rf_wdata_o
);
    localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

    // fetch to queue
    logic                      push_valid;
    logic [loog_pkg::XLEN-1:0] push_pc;
    loog_pkg::inst_word_u      push_inst;
    logic [CNT_W-1:0]          queue_count;

    // queue to execute
    logic                      exec_valid;
    logic [loog_pkg::XLEN-1:0] exec_pc;
    loog_pkg::inst_word_u      exec_inst;
    logic                      exec_allowin;

    fetch_unit #(
        .QUEUE_DEPTH(QUEUE_DEPTH)
    ) u_fetch (
        .clk                 (clk),
        .rst_n_i             (rst_n_i),
        .inst_sram_addr_ok_i (inst_sram_addr_ok_i),
        .inst_sram_data_ok_i (inst_sram_data_ok_i),
        .inst_sram_rdata_i   (inst_sram_rdata_i),
        .queue_count_i       (queue_count),
        .inst_sram_req_o     (inst_sram_req_o),
        .inst_sram_addr_o    (inst_sram_addr_o),
        .push_valid_o        (push_valid),
        .push_pc_o           (push_pc),
        .push_inst_o         (push_inst)
    );

    inst_queue #(
        .QUEUE_DEPTH(QUEUE_DEPTH)
    ) u_queue (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .push_valid_i (push_valid),
        .push_pc_i    (push_pc),
        .push_inst_i  (push_inst),
        .allowin_i    (exec_allowin),
        .out_valid_o  (exec_valid),
        .out_pc_o     (exec_pc),
        .out_inst_o   (exec_inst),
        .count_o      (queue_count)
    );

    exec_unit u_exec (
        .clk                 (clk),
        .rst_n_i             (rst_n_i),
        .in_valid_i          (exec_valid),
        .in_pc_i             (exec_pc),
        .in_inst_i           (exec_inst),
        .allowin_o           (exec_allowin),
        .debug_wb_pc_o       (debug_wb_pc_o),
        .debug_wb_rf_we_o    (debug_wb_rf_we_o),
        .debug_wb_rf_wnum_o  (debug_wb_rf_wnum_o),
        .debug_wb_rf_wdata_o (debug_wb_rf_wdata_o)
    );

endmodule

// File: hw/loog_pkg.sv
// decodes only the 3R and 2RI12 formats of a small LoongArch integer subset; PC starts at 0
package loog_pkg;

    // datapath and register number widths
    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;

    // first fetch address after reset
    localparam logic [XLEN-1:0] RESET_PC = '0;

    // 3R format, major opcode in bits 31:15
    localparam logic [16:0] OP_ADD_W = 17'h00020;
    localparam logic [16:0] OP_SUB_W = 17'h00022;
    localparam logic [16:0] OP_AND   = 17'h00029;
    localparam logic [16:0] OP_OR    = 17'h0002a;
    localparam logic [16:0] OP_XOR   = 17'h0002b;

    // 2RI12 format, opcode in bits 31:22
    localparam logic [9:0] OP_ADDI_W = 10'h00a;
    localparam logic [9:0] OP_ANDI   = 10'h00d;
    localparam logic [9:0] OP_ORI    = 10'h00e;

    // one instruction word, seen through either format
    typedef union packed {
        struct packed {
            logic [16:0]           opcode;
            logic [REG_ADDR_W-1:0] rk;
            logic [REG_ADDR_W-1:0] rj;
            logic [REG_ADDR_W-1:0] rd;
        } r3;
        struct packed {
            logic [9:0]            opcode;
            logic [11:0]           si12;
            logic [REG_ADDR_W-1:0] rj;
            logic [REG_ADDR_W-1:0] rd;
        } ri12;
    } inst_word_u;

endpackage

// File: list.f
hw/loog_pkg.sv
hw/fetch_unit.sv
hw/inst_queue.sv
hw/exec_unit.sv
hw/loog_core.sv
testbench/tb_loog.sv

// File: testbench/loog_cases.txt
# name, instruction word, expected wnum, expected wdata (hex); case n is the word at pc 4*n
# wnum 00 marks a case that retires without a register write
addi_pos    02848c01  01  00000123
addi_neg    02bfec02  02  fffffffb
add_w       00100823  03  0000011e
sub_w       00110824  04  00000128
ori_zext    03bc3c05  05  00000f0f
andi_zext   0363fc46  06  000008fb
and         00149467  07  0000010e
or          00151888  08  000009fb
xor         00158829  09  fffffed8
write_r0    029ffc20  00  00000000
read_r0     0010040a  0a  00000123
bad_opcode  ffffffff  00  00000000
after_bad   0280054b  0b  00000124
sub_neg     00112c0c  0c  fffffedc
addi_chain  02bffd8d  0d  fffffedb
xor_self    0015b5ae  0e  00000000

// File: testbench/tb_loog.sv
// reads testbench/loog_cases.txt relative to the project root; case n is the word at pc 4*n
`timescale 1ns/1ps

module tb_loog;
    localparam int          MAX_CASES    = 64;
    localparam int          RESET_CYCLES = 3;
    localparam int          STALL_CYCLES = 30;
    localparam logic [31:0] STALL_PC     = 32'h0000_0020;

    logic        clk                 = 1'b0;
    logic        rst_n_i;
    logic        inst_sram_req_o;
    logic [31:0] inst_sram_addr_o;
    logic        inst_sram_addr_ok_i = 1'b0;
    logic        inst_sram_data_ok_i = 1'b0;
    logic [31:0] inst_sram_rdata_i   = 32'h0;
    logic [31:0] debug_wb_pc_o;
    logic [3:0]  debug_wb_rf_we_o;
    logic [4:0]  debug_wb_rf_wnum_o;
    logic [31:0] debug_wb_rf_wdata_o;

    logic [8*24-1:0] case_name  [MAX_CASES];
    logic [31:0]     case_word  [MAX_CASES];
    logic [4:0]      case_wnum  [MAX_CASES];
    logic [31:0]     case_wdata [MAX_CASES];
    int              n_cases    = 0;
    int              next_idx   = 0;
    int              pass_cnt   = 0;
    int              fail_cnt   = 0;
    int              cyc        = 0;
    int              stall_left = STALL_CYCLES;
    integer          seed       = 32'he868_fc33;
    // accepted requests still waiting for their data beat
    logic [31:0]     pend_addr  [$];
    int              pend_due   [$];

    loog_core #(
        .QUEUE_DEPTH(4)
    ) DUT (
        .clk                 (clk),
        .rst_n_i             (rst_n_i),
        .inst_sram_req_o     (inst_sram_req_o),
        .inst_sram_addr_o    (inst_sram_addr_o),
        .inst_sram_addr_ok_i (inst_sram_addr_ok_i),
        .inst_sram_data_ok_i (inst_sram_data_ok_i),
        .inst_sram_rdata_i   (inst_sram_rdata_i),
        .debug_wb_pc_o       (debug_wb_pc_o),
        .debug_wb_rf_we_o    (debug_wb_rf_we_o),
        .debug_wb_rf_wnum_o  (debug_wb_rf_wnum_o),
        .debug_wb_rf_wdata_o (debug_wb_rf_wdata_o)
    );

    always #50 clk = ~clk;

    task automatic load_cases();
        int              fd;
        int              got;
        string           line;
        logic [8*24-1:0] name;
        logic [31:0]     word;
        logic [31:0]     wnum;
        logic [31:0]     wdata;
        fd = $fopen("testbench/loog_cases.txt", "r");
        if (fd != 0) begin
            while (!$feof(fd) && n_cases < MAX_CASES) begin
                got = $fgets(line, fd);
                // header lines start with a hash
                if (got > 0 && line[0] != "#") begin
                    if ($sscanf(line, "%s %h %h %h", name, word, wnum, wdata) == 4) begin
                        case_name[n_cases]  = name;
                        case_word[n_cases]  = word;
                        case_wnum[n_cases]  = wnum[4:0];
                        case_wdata[n_cases] = wdata;
                        n_cases = n_cases + 1;
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // program image, zero past the last case
    function automatic logic [31:0] mem_word(logic [31:0] addr);
        int idx;
        idx = int'(addr >> 2);
        if (idx < n_cases) begin
            return case_word[idx];
        end
        return 32'h0;
    endfunction

    task automatic check_retire();
        logic [31:0] exp_pc;
        // no-op cases leave nothing on the trace, order alone covers them
        while (next_idx < n_cases && case_wnum[next_idx] == 5'd0) begin
            $display("ok   %0s  retired without a write", case_name[next_idx]);
            pass_cnt = pass_cnt + 1;
            next_idx = next_idx + 1;
        end
        if (next_idx >= n_cases) begin
            $display("unexpected write to r%0d at pc %h after the last case",
                     debug_wb_rf_wnum_o, debug_wb_pc_o);
            fail_cnt = fail_cnt + 1;
        end else begin
            exp_pc = 32'(next_idx * 4);
            if (debug_wb_rf_we_o == 4'hf && debug_wb_pc_o == exp_pc
                    && debug_wb_rf_wnum_o == case_wnum[next_idx]
                    && debug_wb_rf_wdata_o == case_wdata[next_idx]) begin
                $display("ok   %0s  pc %h  r%0d = %h", case_name[next_idx], exp_pc,
                         case_wnum[next_idx], case_wdata[next_idx]);
                pass_cnt = pass_cnt + 1;
            end else begin
                $display("ERR  %0s  expected we f pc %h r%0d = %h, got we %h pc %h r%0d = %h",
                         case_name[next_idx], exp_pc, case_wnum[next_idx],
                         case_wdata[next_idx], debug_wb_rf_we_o, debug_wb_pc_o,
                         debug_wb_rf_wnum_o, debug_wb_rf_wdata_o);
                fail_cnt = fail_cnt + 1;
            end
            next_idx = next_idx + 1;
        end
    endtask

    // bus is stable mid-cycle, these are the values the next edge sees
    always @(negedge clk) begin
        if (rst_n_i) begin
            if (inst_sram_data_ok_i) begin
                pend_addr.delete(0);
                pend_due.delete(0);
            end
            if (inst_sram_req_o && inst_sram_addr_ok_i) begin
                pend_addr.push_back(inst_sram_addr_o);
                pend_due.push_back(cyc + 1 + int'({$random(seed)} % 4));
            end
            if (debug_wb_rf_we_o != 4'b0000) begin
                check_retire();
            end
        end
    end

    // sram model outputs
    always @(posedge clk) begin
        cyc = cyc + 1;
        #1;
        inst_sram_data_ok_i = 1'b0;
        inst_sram_rdata_i   = 32'h0;
        inst_sram_addr_ok_i = 1'b0;
        if (cyc > RESET_CYCLES) begin
            if (pend_addr.size() > 0 && pend_due[0] <= cyc) begin
                inst_sram_data_ok_i = 1'b1;
                inst_sram_rdata_i   = mem_word(pend_addr[0]);
            end
            // one long refusal at STALL_PC, otherwise a quarter of slots refused
            if (inst_sram_req_o && inst_sram_addr_o == STALL_PC && stall_left > 0) begin
                stall_left = stall_left - 1;
            end else begin
                inst_sram_addr_ok_i = ({$random(seed)} % 4) != 0;
            end
        end
    end

    initial begin
        rst_n_i = 1'b0;
        load_cases();
        if (n_cases == 0) begin
            $display("could not read any case from testbench/loog_cases.txt");
            $display("sim failed");
            $finish;
        end else begin
            repeat (RESET_CYCLES) @(posedge clk);
            #1;
            rst_n_i = 1'b1;
            wait (next_idx >= n_cases);
            // a few more cycles so a stray late write gets caught
            repeat (20) @(posedge clk);
            $display("cases %0d  passed %0d  failed %0d", n_cases, pass_cnt, fail_cnt);
            if (fail_cnt == 0) begin
                $display("sim passed");
            end else begin
                $display("sim failed");
            end
            $finish;
        end
    end

    initial begin
        wait (n_cases > 0);
        #((n_cases * 20 + 50) * 100);
        $display("watchdog: trace stalled after %0d of %0d cases", next_idx, n_cases);
        $display("sim failed");
        $finish;
    end

endmodule
